//--- memSystem.f
+incdir+dv
logic/memSysPkg.sv
logic/cacheRam.sv
logic/cacheWay.sv
logic/wayPicker.sv
logic/mainMemory.sv
logic/cacheCtrl.sv
logic/memSystem.sv
dv/memSystemTb.sv

//--- run.sh
#!/bin/sh
# build the memory system testbench with Verilator and run it
# the exit status of the simulation is the result of the run
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 -Wno-fatal \
   --top-module memSystemTb \
   -f memSystem.f \
   -o memSystemSim

./obj_dir/memSystemSim

//--- dv/memSystemTbModel.svh
//####################################################################
// memory system reference model
// word memory, per-set tags of both ways and the victim bit,
// refAccess gives the expected dataOut and cacheHit of a request
//####################################################################

// expected response of one request
typedef struct packed {memSysPkg::wordT data; logic hit;} expectT;

// word memory keyed by word-aligned byte address, absent means zero
memSysPkg::wordT modelMem [memSysPkg::addrT];
logic            modelValid [2][memSysPkg::numSets];
memSysPkg::tagT  modelTag [2][memSysPkg::numSets];
logic            modelVictim;

function automatic void resetModel();
   modelMem.delete();
   for (int i = 0; i < memSysPkg::numSets; i++) begin
      modelValid[0][i] = 1'b0;
      modelValid[1][i] = 1'b0;
      modelTag[0][i]   = '0;
      modelTag[1][i]   = '0;
   end
   modelVictim = 1'b0;
endfunction

function automatic memSysPkg::wordT readWord(input memSysPkg::addrT addr);
   memSysPkg::addrT key;
   // byte bit of the address is ignored
   key = {addr[15:1], 1'b0};
   if (modelMem.exists(key)) return modelMem[key];
   return '0;
endfunction

function automatic expectT refAccess(input logic isWrite, input memSysPkg::addrT addr,
                                     input memSysPkg::wordT data);
   memSysPkg::tagT   tag;
   memSysPkg::indexT index;
   expectT           result;
   int               way;
   tag        = addr[15:11];
   index      = addr[10:3];
   result.hit = (modelValid[0][index] && (modelTag[0][index] == tag)) ||
                (modelValid[1][index] && (modelTag[1][index] == tag));
   if (!result.hit) begin
      // miss fills an invalid way first, else the victim way
      if (!modelValid[0][index]) way = 0;
      else if (!modelValid[1][index]) way = 1;
      else way = modelVictim ? 1 : 0;
      modelValid[way][index] = 1'b1;
      modelTag[way][index]   = tag;
   end
   if (isWrite) modelMem[{addr[15:1], 1'b0}] = data;
   result.data = readWord(addr);
   // one flip per completed request
   modelVictim = ~modelVictim;
   return result;
endfunction

//--- dv/memSystemTb.sv
//####################################################################
// memory system testbench
// drives strobe requests into the cache, checks every done response
// against the reference model, including hit latency
//####################################################################
`timescale 1ns/1ns

module memSystemTb;

   `include "memSystemTbModel.svh"

   // cycles any single wait may last
   localparam int stepLimit = 200;

   logic              clk;
   logic              rstN;
   memSysPkg::memReqT req;
   memSysPkg::memRspT rsp;
   integer            seed;
   int                cycle = 0;
   // expected responses and their accept cycles in accept order
   expectT            expectQ [$];
   int                acceptQ [$];

   memSystem DUT (.clk(clk), .rstN(rstN), .req(req), .rsp(rsp));

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) cycle <= cycle + 1;

   task automatic stopOnError(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic checkValue(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
      if (actual !== expected) begin
         stopOnError($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected));
      end
   endtask

   // strobe held until a cycle with stall low, where the DUT takes it
   task automatic sendReq(input logic isWrite, input memSysPkg::addrT addr,
                          input memSysPkg::wordT data);
      int waited;
      waited = 0;
      @(posedge clk);
      req <= '{rd: ~isWrite, wr: isWrite, addr: addr, data: data};
      @(negedge clk);
      while (rsp.stall) begin
         waited++;
         if (waited > stepLimit) stopOnError("request never accepted, stall stayed high");
         @(negedge clk);
      end
      expectQ.push_back(refAccess(isWrite, addr, data));
      acceptQ.push_back(cycle);
   endtask

   // drop the strobe and wait for all outstanding responses
   task automatic waitDrained();
      int waited;
      waited = 0;
      @(posedge clk);
      req <= '0;
      while (expectQ.size() != 0) begin
         waited++;
         if (waited > stepLimit) stopOnError("outstanding request never completed");
         @(posedge clk);
      end
   endtask

   // random single-op strobes while the DUT is busy with a miss
   task automatic driveJunk(input int count);
      logic [31:0] r;
      repeat (count) begin
         r = $random(seed);
         @(posedge clk);
         req <= '{rd: r[0], wr: ~r[0], addr: r[31:16], data: r[15:0]};
         @(negedge clk);
         checkValue("stall", 32'(rsp.stall), 32'd1);
      end
   endtask

   //####################################################################
   // compare process
   //####################################################################
   initial begin : compareProc
      expectT want;
      int     acceptedAt;
      int     waited;
      waited = 0;
      forever begin
         @(negedge clk);
         if (rsp.done) begin
            waited = 0;
            if (expectQ.size() == 0) begin
               stopOnError("done pulsed with no request outstanding");
            end else begin
               want       = expectQ.pop_front();
               acceptedAt = acceptQ.pop_front();
               checkValue("stall", 32'(rsp.stall), 32'd0);
               checkValue("dataOut", 32'(rsp.dataOut), 32'(want.data));
               checkValue("cacheHit", 32'(rsp.cacheHit), 32'(want.hit));
               // hit goes idle, compare, done
               if (want.hit) checkValue("hit latency", 32'(cycle - acceptedAt), 32'd2);
            end
         end else if (expectQ.size() != 0) begin
            waited++;
            if (waited > stepLimit) stopOnError("no done within the timeout");
         end
      end
   end

   //####################################################################
   // stimulus
   //####################################################################
   initial begin : stimulus
      logic [31:0]     r;
      logic [31:0]     rData;
      memSysPkg::addrT addr;
      seed = 32'hb0c3;
      rstN = 1'b0;
      req  = '0;
      resetModel();
      repeat (16) @(posedge clk);
      rstN <= 1'b1;
      @(negedge clk);
      checkValue("done", 32'(rsp.done), 32'd0);
      checkValue("stall", 32'(rsp.stall), 32'd0);

      // untouched address reads zero
      sendReq(1'b0, 16'h1234, 16'h0000);
      waitDrained();

      // write miss then read hit
      sendReq(1'b1, 16'h2a16, 16'hbeef);
      sendReq(1'b0, 16'h2a16, 16'h0000);
      waitDrained();

      // three tags on index 0x40 force a dirty eviction
      sendReq(1'b1, {5'h01, 8'h40, 2'd1, 1'b0}, 16'h1111);
      sendReq(1'b1, {5'h02, 8'h40, 2'd1, 1'b0}, 16'h2222);
      sendReq(1'b1, {5'h03, 8'h40, 2'd1, 1'b0}, 16'h3333);
      sendReq(1'b0, {5'h01, 8'h40, 2'd1, 1'b0}, 16'h0000);
      sendReq(1'b0, {5'h02, 8'h40, 2'd1, 1'b0}, 16'h0000);
      sendReq(1'b0, {5'h03, 8'h40, 2'd1, 1'b0}, 16'h0000);
      waitDrained();

      // strobes during the stall of a fresh-set miss are dropped
      sendReq(1'b0, {5'h1e, 8'h80, 2'd2, 1'b0}, 16'h0000);
      driveJunk(5);
      waitDrained();
      repeat (10) @(posedge clk);
      sendReq(1'b0, {5'h02, 8'h40, 2'd1, 1'b0}, 16'h0000);
      waitDrained();

      // random traffic over sets 0x20 to 0x23 and eight tags
      for (int n = 0; n < 300; n++) begin
         r     = $random(seed);
         rData = $random(seed);
         addr  = {2'b00, r[10:8], 6'h08, r[12:11], r[14:13], r[15]};
         sendReq(r[16], addr, rData[15:0]);
         // now and then an idle gap instead of back to back
         if (r[19:17] == 3'd0) begin
            waitDrained();
            repeat (r[21:20]) @(posedge clk);
         end
      end
      waitDrained();

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

//--- logic/memSystem.sv
//####################################################################
// memory system top
// two-way write-back cache in front of the banked main memory,
// strobe request in, response with done, stall and hit out
//####################################################################
`timescale 1ns/1ns

module memSystem (
   input  logic               clk,
   input  logic               rstN,
   input  memSysPkg::memReqT  req,
   output memSysPkg::memRspT  rsp
);

   memSysPkg::cacheCmdT  cacheCmd;
   memSysPkg::wayStatusT way0Status;
   memSysPkg::wayStatusT way1Status;
   memSysPkg::lookupT    lookup;
   memSysPkg::memCmdT    ctrlMemCmd;
   memSysPkg::memCmdT    memCmd;
   memSysPkg::wordT      wayData;
   memSysPkg::wordT      memRdData;
   logic write, latchWay, advance, wrEn0, wrEn1;
   logic memRdValid, done, stall, cacheHit;

   // write-back data is the target way's word
   assign memCmd = '{rd: ctrlMemCmd.rd, wr: ctrlMemCmd.wr, addr: ctrlMemCmd.addr, data: wayData};
   assign rsp    = '{dataOut: wayData, done: done, stall: stall, cacheHit: cacheHit};

   cacheCtrl ctrl (
      .clk (clk), .rstN (rstN), .req (req), .lookup (lookup),
      .memData (memRdData), .memValid (memRdValid), .cmd (cacheCmd),
      .write (write), .latchWay (latchWay), .advance (advance),
      .memCmd (ctrlMemCmd), .done (done), .stall (stall), .cacheHit (cacheHit)
   );

   cacheWay way0 (
      .clk (clk), .rstN (rstN), .cmd (cacheCmd), .wrEn (wrEn0), .status (way0Status)
   );

   cacheWay way1 (
      .clk (clk), .rstN (rstN), .cmd (cacheCmd), .wrEn (wrEn1), .status (way1Status)
   );

   wayPicker picker (
      .clk (clk), .rstN (rstN), .way0 (way0Status), .way1 (way1Status),
      .write (write), .latchWay (latchWay), .advance (advance),
      .wrEn0 (wrEn0), .wrEn1 (wrEn1), .lookup (lookup), .dataOut (wayData)
   );

   mainMemory mem (
      .clk (clk), .cmd (memCmd), .rdData (memRdData), .rdValid (memRdValid), .rstN (rstN)
   );

endmodule

//--- logic/cacheCtrl.sv
//####################################################################
// cache controller
// accepts single-cycle strobes, compares, writes back a dirty victim,
// refills the line with two reads in flight, applies a pending write
//####################################################################
`timescale 1ns/1ns

module cacheCtrl (
   input  logic                clk,
   input  logic                rstN,
   input  memSysPkg::memReqT   req,
   input  memSysPkg::lookupT   lookup,
   input  memSysPkg::wordT     memData,
   input  logic                memValid,
   output memSysPkg::cacheCmdT cmd,
   output logic                write,
   output logic                latchWay,
   output logic                advance,
   output memSysPkg::memCmdT   memCmd,
   output logic                done,
   output logic                stall,
   output logic                cacheHit
);

   memSysPkg::ctrlStateT state;
   memSysPkg::ctrlStateT nextState;
   memSysPkg::addrT      reqAddr;
   memSysPkg::wordT      reqData;
   logic                 reqWrite;
   logic                 hitReg;
   logic                 accept;
   logic                 fillWrite;
   logic [1:0]           issueCnt;
   logic [1:0]           retCnt;
   memSysPkg::tagT       reqTag;
   memSysPkg::indexT     reqIndex;
   memSysPkg::lineWordT  reqWord;

   assign reqTag   = reqAddr[15:11];
   assign reqIndex = reqAddr[10:3];
   assign reqWord  = reqAddr[2:1];

   // new strobes only in idle or done, exactly one of rd and wr
   assign accept = ((state == memSysPkg::idle) || (state == memSysPkg::done)) &&
                   (req.rd ^ req.wr);

   // returned memory word lands in the target way this cycle
   assign fillWrite = memValid &&
                      ((state == memSysPkg::fillIssue) || (state == memSysPkg::fillWait));

   //####################################################################
   // state register and counters
   //####################################################################
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         state    <= memSysPkg::idle;
         reqWrite <= 1'b0;
         hitReg   <= 1'b0;
         issueCnt <= '0;
         retCnt   <= '0;
      end else begin
         state <= nextState;
         if (accept) reqWrite <= req.wr;
         if (state == memSysPkg::compare) hitReg <= lookup.hit;
         // wraps back to zero after the fourth word of a burst
         if ((state == memSysPkg::evict) || (state == memSysPkg::fillIssue)) begin
            issueCnt <= issueCnt + 2'd1;
         end
         if (fillWrite) retCnt <= retCnt + 2'd1;
      end
   end

   // request payload
   always_ff @(posedge clk) begin
      if (accept) begin
         reqAddr <= req.addr;
         reqData <= req.data;
      end
   end

   always_comb begin
      nextState = state;
      case (state)
         memSysPkg::idle, memSysPkg::done: begin
            nextState = accept ? memSysPkg::compare : memSysPkg::idle;
         end
         memSysPkg::compare: begin
            if (lookup.hit) nextState = memSysPkg::done;
            else if (lookup.victimDirty) nextState = memSysPkg::evict;
            else nextState = memSysPkg::fillIssue;
         end
         memSysPkg::evict: begin
            if (issueCnt == 2'd3) nextState = memSysPkg::fillIssue;
         end
         memSysPkg::fillIssue: begin
            if (issueCnt == 2'd3) nextState = memSysPkg::fillWait;
         end
         memSysPkg::fillWait: begin
            // last word back, pending write still to apply
            if (fillWrite && (retCnt == 2'd3)) begin
               nextState = reqWrite ? memSysPkg::finishWrite : memSysPkg::done;
            end
         end
         memSysPkg::finishWrite: nextState = memSysPkg::done;
         default: nextState = memSysPkg::idle;
      endcase
   end

   //####################################################################
   // cache and memory commands
   //####################################################################
   assign write = ((state == memSysPkg::compare) && lookup.hit && reqWrite) || fillWrite ||
                  (state == memSysPkg::finishWrite);

   assign cmd.index = reqIndex;
   assign cmd.tag   = reqTag;
   // fill uses the return count, write-back the issue count
   assign cmd.word  = fillWrite ? retCnt :
                      (state == memSysPkg::evict) ? issueCnt : reqWord;
   assign cmd.data  = fillWrite ? memData : reqData;
   assign cmd.fill  = fillWrite;
   assign cmd.write = write;

   assign memCmd.rd   = (state == memSysPkg::fillIssue);
   assign memCmd.wr   = (state == memSysPkg::evict);
   assign memCmd.addr = {(state == memSysPkg::evict) ? lookup.victimTag : reqTag,
                         reqIndex, issueCnt, 1'b0};
   // victim word comes from the target way, merged in at the top level
   assign memCmd.data = '0;

   assign latchWay = (state == memSysPkg::compare);
   assign advance  = (state == memSysPkg::done);
   assign done     = (state == memSysPkg::done);
   assign stall    = (state != memSysPkg::idle) && (state != memSysPkg::done);
   assign cacheHit = (state == memSysPkg::done) && hitReg;

endmodule

//--- logic/mainMemory.sv
//####################################################################
// banked main memory
// four word banks selected by the word bits of the address,
// pipelined read (address stage then data stage), one cycle write
//####################################################################
`timescale 1ns/1ns

module mainMemory (
   input  logic              clk,
   input  memSysPkg::memCmdT cmd,
   output memSysPkg::wordT   rdData,
   output logic              rdValid,
   input  logic              rstN
);

   localparam int numBanks = memSysPkg::wordsPerLine;
   localparam int rowWidth = $clog2(memSysPkg::bankDepth);

   memSysPkg::wordT bankMem [numBanks][memSysPkg::bankDepth] = '{default: '0};

   logic [memSysPkg::memReadLatency-1:0] rdPipe;
   memSysPkg::addrT                      rdAddrQ;
   logic [1:0]                           wrBank;
   logic [rowWidth-1:0]                  wrRow;
   logic [1:0]                           rdBank;
   logic [rowWidth-1:0]                  rdRow;

   // byte address split
   // bit 0 ignored, bits 2:1 bank, upper bits row
   assign wrBank = cmd.addr[2:1];
   assign wrRow  = cmd.addr[memSysPkg::addrWidth-1:3];
   assign rdBank = rdAddrQ[2:1];
   assign rdRow  = rdAddrQ[memSysPkg::addrWidth-1:3];

   //####################################################################
   // banks and read datapath
   //####################################################################
   always_ff @(posedge clk) begin
      if (cmd.wr) bankMem[wrBank][wrRow] <= cmd.data;
      // address stage
      if (cmd.rd) rdAddrQ <= cmd.addr;
      // data stage
      if (rdPipe[0]) rdData <= bankMem[rdBank][rdRow];
   end

   // read valid travels alongside the address and data stages
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         rdPipe <= '0;
      end else begin
         rdPipe <= {rdPipe[memSysPkg::memReadLatency-2:0], cmd.rd};
      end
   end

   assign rdValid = rdPipe[memSysPkg::memReadLatency-1];

endmodule

//--- logic/wayPicker.sv
//####################################################################
// way picker
// victim bit, target way choice and hold, write routing to the
// target way, victim summary and read data select
//####################################################################
`timescale 1ns/1ns

module wayPicker (
   input  logic                 clk,
   input  logic                 rstN,
   input  memSysPkg::wayStatusT way0,
   input  memSysPkg::wayStatusT way1,
   input  logic                 write,
   input  logic                 latchWay,
   input  logic                 advance,
   output logic                 wrEn0,
   output logic                 wrEn1,
   output memSysPkg::lookupT    lookup,
   output memSysPkg::wordT      dataOut
);

   logic                 victim;
   logic                 pickWay;
   logic                 wayReg;
   logic                 sel;
   memSysPkg::wayStatusT target;

   // hit way first, then an invalid way, then the victim
   always_comb begin
      if (way0.hit) pickWay = 1'b0;
      else if (way1.hit) pickWay = 1'b1;
      else if (!way0.valid) pickWay = 1'b0;
      else if (!way1.valid) pickWay = 1'b1;
      else pickWay = victim;
   end

   // live choice during compare, held choice afterwards
   assign sel = latchWay ? pickWay : wayReg;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         victim <= 1'b0;
         wayReg <= 1'b0;
      end else begin
         if (latchWay) wayReg <= pickWay;
         // flips once per completed request
         if (advance) victim <= ~victim;
      end
   end

   assign target = sel ? way1 : way0;

   // only the target way sees the write
   assign wrEn0 = write & ~sel;
   assign wrEn1 = write & sel;

   assign lookup.hit         = way0.hit | way1.hit;
   assign lookup.victimDirty = target.valid & target.dirty;
   assign lookup.victimTag   = target.tag;

   assign dataOut = target.data;

endmodule

//--- logic/cacheWay.sv
//####################################################################
// one cache way
// tag store per set and data store per word, tag compare for hit,
// user writes mark the entry dirty, fill writes load a clean line
//####################################################################
`timescale 1ns/1ns

module cacheWay (
   input  logic                  clk,
   input  logic                  rstN,
   input  memSysPkg::cacheCmdT   cmd,
   input  logic                  wrEn,
   output memSysPkg::wayStatusT  status
);

   localparam int dataDepth = memSysPkg::numSets * memSysPkg::wordsPerLine;

   memSysPkg::tagEntryT entry;
   memSysPkg::tagEntryT newEntry;
   memSysPkg::wordT     word;
   logic                doWrite;

   // picker enable, qualified by the command itself
   assign doWrite = wrEn & cmd.write;

   // entry after a write
   // fill brings a clean line under the new tag, user data dirties it
   assign newEntry.valid = 1'b1;
   assign newEntry.dirty = ~cmd.fill;
   assign newEntry.tag   = cmd.tag;

   cacheRam #(
      .payloadT (memSysPkg::tagEntryT),
      .depth    (memSysPkg::numSets)
   ) tagStore (
      .clk     (clk),
      .rstN    (rstN),
      .rdIndex (cmd.index),
      .rdData  (entry),
      .wrEn    (doWrite),
      .wrIndex (cmd.index),
      .wrData  (newEntry)
   );

   // data words addressed by set and word slot
   cacheRam #(
      .payloadT (memSysPkg::wordT),
      .depth    (dataDepth)
   ) dataStore (
      .clk     (clk),
      .rstN    (rstN),
      .rdIndex ({cmd.index, cmd.word}),
      .rdData  (word),
      .wrEn    (doWrite),
      .wrIndex ({cmd.index, cmd.word}),
      .wrData  (cmd.data)
   );

   //####################################################################
   // lookup result
   //####################################################################
   assign status.hit   = entry.valid & (entry.tag == cmd.tag);
   assign status.valid = entry.valid;
   assign status.dirty = entry.dirty;
   assign status.tag   = entry.tag;
   assign status.data  = word;

endmodule

//--- logic/cacheRam.sv
//####################################################################
// cache storage array
// reset-cleared, combinational read port and clocked write port,
// payload type chosen per instance (tag entries or data words)
//####################################################################
`timescale 1ns/1ns

module cacheRam #(
   parameter type payloadT = memSysPkg::wordT,
   parameter int  depth    = memSysPkg::numSets
) (
   input  logic                     clk,
   input  logic                     rstN,
   input  logic [$clog2(depth)-1:0] rdIndex,
   output payloadT                  rdData,
   input  logic                     wrEn,
   input  logic [$clog2(depth)-1:0] wrIndex,
   input  payloadT                  wrData
);

   payloadT mem [depth];

   // asynchronous read
   assign rdData = mem[rdIndex];

   // whole array cleared on reset so every entry starts invalid
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < depth; i++) begin
            mem[i] <= '0;
         end
      end else if (wrEn) begin
         mem[wrIndex] <= wrData;
      end
   end

endmodule

//--- logic/memSysPkg.sv
//####################################################################
// memory system package
// sizes, address fields, bus structs and controller state encoding
// shared by the cache, the controller and the banked main memory
//####################################################################
package memSysPkg;

   // address and cache geometry
   localparam int addrWidth      = 16;
   localparam int dataWidth      = 16;
   localparam int tagWidth       = 5;
   localparam int indexWidth     = 8;
   localparam int wordsPerLine   = 4;
   localparam int numSets        = 256;
   // cycles from a memory rd command to rdValid
   localparam int memReadLatency = 2;
   // rows per memory bank, one bank per word slot of a line
   localparam int bankDepth      = 8192;

   typedef logic [addrWidth-1:0]  addrT;
   typedef logic [dataWidth-1:0]  wordT;
   typedef logic [tagWidth-1:0]   tagT;
   typedef logic [indexWidth-1:0] indexT;
   typedef logic [1:0]            lineWordT;

   // user request, valid in the strobe cycle only
   typedef struct packed {logic rd; logic wr; addrT addr; wordT data;} memReqT;

   // user response
   typedef struct packed {wordT dataOut; logic done; logic stall; logic cacheHit;} memRspT;

   // per-set state of one way
   typedef struct packed {logic valid; logic dirty; tagT tag;} tagEntryT;

   // controller command broadcast to both ways
   // fill high: store memory data, entry valid and clean
   typedef struct packed {
      indexT    index;
      lineWordT word;
      tagT      tag;
      wordT     data;
      logic     fill;
      logic     write;
   } cacheCmdT;

   // lookup result of one way
   typedef struct packed {logic hit; logic valid; logic dirty; tagT tag; wordT data;} wayStatusT;

   // picker summary for the controller
   typedef struct packed {logic hit; logic victimDirty; tagT victimTag;} lookupT;

   // controller command to main memory
   typedef struct packed {logic rd; logic wr; addrT addr; wordT data;} memCmdT;

   typedef enum logic [2:0] {
      idle, compare, evict, fillIssue, fillWait, finishWrite, done
   } ctrlStateT;

endpackage
